//--- logic/zbt_pkg.sv
//--------------------
// widths, depths and pipeline latency shared by the ZBT controller,
// SRAM model, response FIFO and testbench; import with zbt_pkg::*
//--------------------
`default_nettype none

package zbt_pkg;

  // word address and data widths
  localparam int ADDR_W = 10;
  localparam int DATA_W = 32;

  localparam int MEM_DEPTH = 1024; // words per SRAM

  // edges from address on the pins to read data valid or write done
  localparam int SRAM_LAT = 2;

  // response FIFO sizing
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

//--- logic/zbt_sram.sv
//--------------------
// pipelined ZBT SRAM model, the address passes two registers
//--------------------
`timescale 1ns/1ns
`default_nettype none

module zbt_sram
  import zbt_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire addr_t addr,
  input  wire logic  we_n,
  input  wire data_t wdata,
  output data_t      rdata
);

  data_t mem [MEM_DEPTH];

  addr_t addr_p;
  addr_t addr_pp;
  logic  we_p;
  data_t wdata_p;

  // write data follows the first address stage
  always_ff @(posedge clk)
  begin
    wdata_p <= wdata;
  end

  // a write in the first stage lands on the edge that fills the second
  // stage, so a read issued one cycle later already sees it
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      addr_p  <= '0;
      addr_pp <= '0;
      we_p    <= 1'b1; // pipeline holds reads
      for (int i = 0; i < MEM_DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else
    begin
      addr_p  <= addr;
      we_p    <= we_n;
      addr_pp <= addr_p;
      if (!we_p)
      begin
        mem[addr_p] <= wdata_p;
      end
    end
  end

  // flow-through read from the second address stage
  assign rdata = mem[addr_pp];

endmodule

`default_nettype wire

//--- logic/zbt_rsp_fifo.sv
//--------------------
// read response FIFO, pushed by the controller, popped with valid/ready
//--------------------
`timescale 1ns/1ns
`default_nettype none

module zbt_rsp_fifo
  import zbt_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        push,
  input  wire data_t       push_data,
  input  wire logic        pop_ready,
  output logic             pop_valid,
  output data_t            pop_data,
  output logic [CNT_W-1:0] count
);

  data_t            slot [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_pop;

  assign pop_valid = (count != '0);
  assign pop_data  = slot[rd_ptr];
  assign do_pop    = pop_valid && pop_ready;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      slot[wr_ptr] <= push_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // none or both
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/zbt_ctrl.sv
//--------------------
// one ZBT channel: accepts requests, drives the SRAM pins, returns reads
//--------------------
`timescale 1ns/1ns
`default_nettype none

module zbt_ctrl
  import zbt_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,

  input  wire logic  req_valid,
  output logic       req_ready,
  input  wire logic  req_we,
  input  wire addr_t req_addr,
  input  wire data_t req_wdata,

  output logic       rsp_valid,
  input  wire logic  rsp_ready,
  output data_t      rsp_rdata,

  output addr_t      sram_addr,
  output logic       sram_we_n,
  output data_t      sram_wdata,
  input  wire data_t sram_rdata
);

  logic accept;

  // accepted request, one cycle ahead of the pins
  logic  acc_we;
  logic  acc_rd;
  addr_t acc_addr;
  data_t acc_wdata;

  // live reads, aligned with pins, first and second SRAM stage
  logic [SRAM_LAT:0] rd_track;

  logic             push;
  logic [CNT_W-1:0] fifo_count;
  logic [CNT_W-1:0] rd_inflight;
  logic [CNT_W:0]   credit_used;

  assign accept = req_valid && req_ready;

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      acc_we   <= 1'b0;
      acc_rd   <= 1'b0;
      acc_addr <= '0;
    end
    else if (accept)
    begin
      acc_we   <= req_we;
      acc_rd   <= !req_we;
      acc_addr <= req_addr;
    end
    else
    begin
      acc_we <= 1'b0; // idle slot is a dead read of the last address
      acc_rd <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      acc_wdata <= req_wdata;
    end
  end

  // pin registers
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      sram_addr <= '0;
      sram_we_n <= 1'b1;
    end
    else
    begin
      sram_addr <= acc_addr;
      sram_we_n <= !acc_we;
    end
  end

  always_ff @(posedge clk)
  begin
    sram_wdata <= acc_wdata;
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      rd_track <= '0;
    end
    else
    begin
      rd_track <= {rd_track[SRAM_LAT-1:0], acc_rd};
    end
  end

  // top bit set means sram_rdata holds that read's word now
  assign push = rd_track[SRAM_LAT];

  // credit: every read not yet in the FIFO holds a slot
  always_comb
  begin
    rd_inflight = CNT_W'(acc_rd);
    for (int k = 0; k <= SRAM_LAT; k++)
    begin
      rd_inflight = rd_inflight + CNT_W'(rd_track[k]);
    end
  end

  assign credit_used = {1'b0, fifo_count} + {1'b0, rd_inflight};
  assign req_ready   = (credit_used < (CNT_W + 1)'(FIFO_DEPTH));

  zbt_rsp_fifo u_rsp_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (sram_rdata),
    .pop_ready (rsp_ready),
    .pop_valid (rsp_valid),
    .pop_data  (rsp_rdata),
    .count     (fifo_count)
  );

endmodule

`default_nettype wire

//--- logic/dual_zbt_top.sv
//--------------------
// two independent ZBT channels, each a controller and its own SRAM
//--------------------
`timescale 1ns/1ns
`default_nettype none

module dual_zbt_top
  import zbt_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,

  input  wire logic  req_valid_1,
  output logic       req_ready_1,
  input  wire logic  req_we_1,
  input  wire addr_t req_addr_1,
  input  wire data_t req_wdata_1,
  output logic       rsp_valid_1,
  input  wire logic  rsp_ready_1,
  output data_t      rsp_rdata_1,

  input  wire logic  req_valid_2,
  output logic       req_ready_2,
  input  wire logic  req_we_2,
  input  wire addr_t req_addr_2,
  input  wire data_t req_wdata_2,
  output logic       rsp_valid_2,
  input  wire logic  rsp_ready_2,
  output data_t      rsp_rdata_2
);

  addr_t sram_addr_1;
  logic  sram_we_n_1;
  data_t sram_wdata_1;
  data_t sram_rdata_1;

  addr_t sram_addr_2;
  logic  sram_we_n_2;
  data_t sram_wdata_2;
  data_t sram_rdata_2;

  zbt_ctrl u_ctrl_1 (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid_1),
    .req_ready  (req_ready_1),
    .req_we     (req_we_1),
    .req_addr   (req_addr_1),
    .req_wdata  (req_wdata_1),
    .rsp_valid  (rsp_valid_1),
    .rsp_ready  (rsp_ready_1),
    .rsp_rdata  (rsp_rdata_1),
    .sram_addr  (sram_addr_1),
    .sram_we_n  (sram_we_n_1),
    .sram_wdata (sram_wdata_1),
    .sram_rdata (sram_rdata_1)
  );

  zbt_sram u_sram_1 (
    .clk   (clk),
    .rst   (rst),
    .addr  (sram_addr_1),
    .we_n  (sram_we_n_1),
    .wdata (sram_wdata_1),
    .rdata (sram_rdata_1)
  );

  zbt_ctrl u_ctrl_2 (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid_2),
    .req_ready  (req_ready_2),
    .req_we     (req_we_2),
    .req_addr   (req_addr_2),
    .req_wdata  (req_wdata_2),
    .rsp_valid  (rsp_valid_2),
    .rsp_ready  (rsp_ready_2),
    .rsp_rdata  (rsp_rdata_2),
    .sram_addr  (sram_addr_2),
    .sram_we_n  (sram_we_n_2),
    .sram_wdata (sram_wdata_2),
    .sram_rdata (sram_rdata_2)
  );

  zbt_sram u_sram_2 (
    .clk   (clk),
    .rst   (rst),
    .addr  (sram_addr_2),
    .we_n  (sram_we_n_2),
    .wdata (sram_wdata_2),
    .rdata (sram_rdata_2)
  );

endmodule

`default_nettype wire

//--- dv/tb_checks.svh
//--------------------
// compare tasks and bounded waits, included inside the testbench module
//--------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run(input string why);
  $display("%s", why);
  $display(">>> FAIL");
  $fatal(1, "stopped at the first error");
endtask

task automatic compare_data(input string name, input data_t exp, input data_t act);
  if (act !== exp)
  begin
    abort_run($sformatf("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act));
  end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
  if (act !== exp)
  begin
    abort_run($sformatf("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act));
  end
endtask

// keeps valid and payload driven until the channel takes the request
task automatic wait_req_ready(input int ch);
  int waited;
  waited = 0;
  while (!ready_of(ch))
  begin
    if (waited == REQ_TIMEOUT)
    begin
      abort_run($sformatf("request not accepted on channel %0d after %0d cycles", ch, waited));
    end
    tick();
    waited++;
  end
endtask

task automatic wait_responses();
  int waited;
  waited = 0;
  while (exp_q_1.size() != 0 || exp_q_2.size() != 0)
  begin
    if (waited == RSP_TIMEOUT)
    begin
      abort_run($sformatf("response missing, %0d reads on channel 1 and %0d on channel 2 %s",
                          exp_q_1.size(), exp_q_2.size(), "never came back"));
    end
    idle_cycles(1);
    waited++;
  end
endtask

`endif

//--- dv/tb_dual_zbt.sv
//--------------------
// testbench for the dual ZBT controller, applies a stimulus table to both
// channels and checks read data against a reference memory per channel
//--------------------
`timescale 1ns/1ns
`default_nettype none

module tb_dual_zbt
  import zbt_pkg::*;
();

  localparam int REQ_TIMEOUT = 64;
  localparam int RSP_TIMEOUT = 200;
  localparam int POOL_SIZE   = 8;

  typedef struct packed {
    int    ch;      // 1 or 2
    logic  we;
    int    pool;    // -1 literal row, else random pool entry
    addr_t addr;
    data_t wdata;
    int    gap;     // idle cycles before the request
    int    holdoff; // cycles rsp_ready stays low from this row
  } row_t;

  logic  clk;
  logic  rst;
  logic  req_valid_1;
  logic  req_ready_1;
  logic  req_we_1;
  addr_t req_addr_1;
  data_t req_wdata_1;
  logic  rsp_valid_1;
  logic  rsp_ready_1;
  data_t rsp_rdata_1;
  logic  req_valid_2;
  logic  req_ready_2;
  logic  req_we_2;
  addr_t req_addr_2;
  data_t req_wdata_2;
  logic  rsp_valid_2;
  logic  rsp_ready_2;
  data_t rsp_rdata_2;

  row_t  stim_rows [$];
  addr_t pool_addr [POOL_SIZE];
  data_t pool_data [POOL_SIZE];
  data_t ref_mem_1 [MEM_DEPTH];
  data_t ref_mem_2 [MEM_DEPTH];
  data_t exp_q_1 [$]; // reads owed, in request order
  data_t exp_q_2 [$];
  int    hold_1;
  int    hold_2;
  int    seed;

  dual_zbt_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .req_valid_1 (req_valid_1),
    .req_ready_1 (req_ready_1),
    .req_we_1    (req_we_1),
    .req_addr_1  (req_addr_1),
    .req_wdata_1 (req_wdata_1),
    .rsp_valid_1 (rsp_valid_1),
    .rsp_ready_1 (rsp_ready_1),
    .rsp_rdata_1 (rsp_rdata_1),
    .req_valid_2 (req_valid_2),
    .req_ready_2 (req_ready_2),
    .req_we_2    (req_we_2),
    .req_addr_2  (req_addr_2),
    .req_wdata_2 (req_wdata_2),
    .rsp_valid_2 (rsp_valid_2),
    .rsp_ready_2 (rsp_ready_2),
    .rsp_rdata_2 (rsp_rdata_2)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20 clk = ~clk;
    end
  end

  function automatic logic ready_of(input int ch);
    return (ch == 1) ? req_ready_1 : req_ready_2;
  endfunction

  task automatic add_row(input int ch, input logic we, input int pool, input addr_t addr,
                         input data_t wdata, input int gap, input int holdoff);
    stim_rows.push_back(row_t'{ch, we, pool, addr, wdata, gap, holdoff});
  endtask

  // checks credit and collects responses, all on the falling edge
  task automatic service_responses(input int ch);
    logic  valid;
    logic  ready;
    logic  credit_ok;
    data_t rdata;
    data_t expected;
    int    pending;
    valid     = (ch == 1) ? rsp_valid_1 : rsp_valid_2;
    ready     = (ch == 1) ? rsp_ready_1 : rsp_ready_2;
    credit_ok = (ch == 1) ? req_ready_1 : req_ready_2;
    rdata     = (ch == 1) ? rsp_rdata_1 : rsp_rdata_2;
    pending   = (ch == 1) ? exp_q_1.size() : exp_q_2.size();
    // every read owed holds one FIFO slot until it is popped
    compare_bit($sformatf("req_ready_%0d", ch), pending < FIFO_DEPTH, credit_ok);
    if (pending == 0)
    begin
      compare_bit($sformatf("rsp_valid_%0d", ch), 1'b0, valid);
    end
    else if (valid && ready)
    begin
      expected = (ch == 1) ? exp_q_1.pop_front() : exp_q_2.pop_front();
      compare_data($sformatf("rsp_rdata_%0d", ch), expected, rdata);
    end
  endtask

  task automatic tick();
    @(negedge clk);
    rsp_ready_1 = (hold_1 == 0);
    rsp_ready_2 = (hold_2 == 0);
    if (hold_1 > 0)
      hold_1--;
    if (hold_2 > 0)
      hold_2--;
    service_responses(1);
    service_responses(2);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
    begin
      tick();
      req_valid_1 = 1'b0;
      req_valid_2 = 1'b0;
    end
  endtask

  task automatic record_accept(input int ch, input logic we, input addr_t addr,
                               input data_t wdata);
    if (ch == 1 && we)
      ref_mem_1[addr] = wdata;
    else if (ch == 1)
      exp_q_1.push_back(ref_mem_1[addr]);
    else if (we)
      ref_mem_2[addr] = wdata;
    else
      exp_q_2.push_back(ref_mem_2[addr]);
  endtask

  task automatic send_request(input int ch, input logic we, input addr_t addr,
                              input data_t wdata);
    tick();
    req_valid_1 = (ch == 1);
    req_valid_2 = (ch == 2);
    if (ch == 1)
    begin
      req_we_1    = we;
      req_addr_1  = addr;
      req_wdata_1 = wdata;
    end
    else
    begin
      req_we_2    = we;
      req_addr_2  = addr;
      req_wdata_2 = wdata;
    end
    wait_req_ready(ch);
    record_accept(ch, we, addr, wdata); // taken on the next rising edge
  endtask

  task automatic apply_row(input row_t r);
    addr_t addr;
    data_t wdata;
    addr  = (r.pool >= 0) ? pool_addr[r.pool] : r.addr;
    wdata = (r.pool >= 0) ? pool_data[r.pool] : r.wdata;
    if (r.holdoff > 0 && r.ch == 1)
      hold_1 = r.holdoff;
    else if (r.holdoff > 0)
      hold_2 = r.holdoff;
    idle_cycles(r.gap);
    send_request(r.ch, r.we, addr, wdata);
  endtask

  task automatic build_table();
    add_row(1, 1'b0, -1, 10'h005, 32'h0, 0, 0); // unwritten words read 0
    add_row(2, 1'b0, -1, 10'h3ff, 32'h0, 0, 0);
    add_row(1, 1'b1, -1, 10'h010, 32'hcafe_f00d, 2, 0);
    add_row(1, 1'b0, -1, 10'h010, 32'h0, 0, 0); // read right after the write
    add_row(2, 1'b1, -1, 10'h020, 32'h1234_5678, 0, 0);
    add_row(2, 1'b0, -1, 10'h020, 32'h0, 0, 0);
    add_row(1, 1'b1, -1, 10'h010, 32'h0bad_beef, 0, 0);
    add_row(1, 1'b0, -1, 10'h010, 32'h0, 0, 0);
    for (int k = 0; k < POOL_SIZE; k++)
      add_row((k < 6) ? 1 : 2, 1'b1, k, 10'h0, 32'h0, 0, 0);
    for (int k = 0; k < POOL_SIZE; k++)
      add_row((k < 6) ? 1 : 2, 1'b0, k, 10'h0, 32'h0, 0, 0);
    // responses stalled, the fifth read has to wait for credit
    add_row(1, 1'b0, 0, 10'h0, 32'h0, 4, 24);
    for (int k = 1; k < 6; k++)
      add_row(1, 1'b0, k, 10'h0, 32'h0, 0, 0);
    add_row(2, 1'b0, 6, 10'h0, 32'h0, 0, 10);
    add_row(2, 1'b0, 7, 10'h0, 32'h0, 0, 0);
    add_row(1, 1'b1, -1, 10'h155, 32'h1111_1111, 4, 0);
    add_row(2, 1'b1, -1, 10'h155, 32'h2222_2222, 0, 0);
    add_row(1, 1'b0, -1, 10'h155, 32'h0, 0, 0);
    add_row(2, 1'b0, -1, 10'h155, 32'h0, 0, 0);
    add_row(2, 1'b0, -1, 10'h010, 32'h0, 0, 0); // only channel 1 wrote here
  endtask

  initial
  begin
    rst          = 1'b0;
    req_valid_1  = 1'b0;
    req_we_1     = 1'b0;
    req_addr_1   = '0;
    req_wdata_1  = '0;
    rsp_ready_1  = 1'b1;
    req_valid_2  = 1'b0;
    req_we_2     = 1'b0;
    req_addr_2   = '0;
    req_wdata_2  = '0;
    rsp_ready_2  = 1'b1;
    hold_1       = 0;
    hold_2       = 0;
    seed         = 32'h415c;
    foreach (ref_mem_1[a])
    begin
      ref_mem_1[a] = '0;
      ref_mem_2[a] = '0;
    end
    for (int k = 0; k < POOL_SIZE; k++)
    begin
      pool_addr[k] = addr_t'($random(seed));
      pool_data[k] = data_t'($random(seed));
    end
    build_table();
    repeat (3) @(negedge clk);
    rst = 1'b1;
    compare_bit("rsp_valid_1", 1'b0, rsp_valid_1);
    compare_bit("rsp_valid_2", 1'b0, rsp_valid_2);
    compare_bit("req_ready_1", 1'b1, req_ready_1);
    compare_bit("req_ready_2", 1'b1, req_ready_2);
    foreach (stim_rows[i])
      apply_row(stim_rows[i]);
    wait_responses();
    idle_cycles(4);
    $display(">>> PASS");
    $finish;
  end

  `include "tb_checks.svh"

endmodule

`default_nettype wire

//--- zbt_mem.f
+incdir+dv
logic/zbt_pkg.sv
logic/zbt_sram.sv
logic/zbt_rsp_fifo.sv
logic/zbt_ctrl.sv
logic/dual_zbt_top.sv
dv/tb_dual_zbt.sv

//--- run.sh
#!/bin/sh
# build the dual ZBT testbench with Verilator and run it
# the exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module tb_dual_zbt \
    -f zbt_mem.f -o sim_dual_zbt &&
  ./obj_dir/sim_dual_zbt &&
  echo "simulation ended without errors" ||
  { echo "build or simulation failed"; exit 1; }
